/* design/exec_cfg.svh */
// Size parameters of the execute path, included by the package and by RTL that needs them
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Lanes per vector register
// Lane 0 is the scalar lane and also carries the branch condition
`define VECTOR_LANES 4

// Hardware threads interleaved through the pipeline
`define THREADS_PER_CORE 4

// Architectural registers per thread
`define NUM_REGISTERS 32

`endif

/* design/exec_pkg.sv */
// Shared types of the execute path; modules import this package where they use its types
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

	// Plain value widths
	typedef logic [31:0] scalar_t;
	typedef scalar_t [`VECTOR_LANES-1:0] vector_t;
	typedef logic [`VECTOR_LANES-1:0] lane_mask_t;
	typedef logic [$clog2(`THREADS_PER_CORE)-1:0] thread_idx_t;
	typedef logic [$clog2(`NUM_REGISTERS)-1:0] reg_idx_t;

	// Integer operations of the single cycle pipe
	typedef enum logic [5:0] {
		OP_OR, OP_AND, OP_XOR,
		OP_IADD, OP_ISUB,
		OP_LSL, OP_LSR, OP_ASR,
		OP_CLZ, OP_CTZ, OP_COPY,
		OP_EQUAL, OP_NEQUAL,
		OP_SIGTR, OP_SIGTE, OP_SILT, OP_SILTE,
		OP_UIGTR, OP_UIGTE, OP_UILT, OP_UILTE,
		OP_SEXT8, OP_SEXT16,
		OP_SHUFFLE, OP_GETLANE
	} alu_op_t;

	typedef enum logic [2:0] {
		BRANCH_ALL           = 3'b000,
		BRANCH_ZERO          = 3'b001,
		BRANCH_NOT_ZERO      = 3'b010,
		BRANCH_ALWAYS        = 3'b011,
		BRANCH_CALL_OFFSET   = 3'b100,
		BRANCH_NOT_ALL       = 3'b101,
		BRANCH_CALL_REGISTER = 3'b110
	} branch_type_t;

	// Instruction as delivered by operand fetch
	typedef struct packed {
		scalar_t pc;
		alu_op_t alu_op;
		logic is_branch;
		branch_type_t branch_type;
		scalar_t immediate_value;
		logic has_dest;
		reg_idx_t dest_reg;
	} decoded_instruction_t;

endpackage

`default_nettype wire

/* design/lane_alu.sv */
// Integer ALU for one vector lane; the execute stage instantiates one per lane
`timescale 1ns/1ns
`default_nettype none

`include "exec_cfg.svh"

module lane_alu
	import exec_pkg::*;
(
	input  alu_op_t alu_op,
	input  scalar_t operand1,
	input  scalar_t operand2,
	input  vector_t vector_operand1,
	output scalar_t result
);
	localparam int LANE_SEL_W = $clog2(`VECTOR_LANES);

	scalar_t difference;
	logic borrow;
	logic overflow;
	logic zero;
	logic signed_gtr;
	logic compare;
	logic [5:0] lz;
	logic [5:0] tz;
	logic shift_in_sign;
	logic [63:0] rshift_ext;
	logic [LANE_SEL_W-1:0] lane_sel;

	// One extra bit on the subtract gives the unsigned borrow
	assign {borrow, difference} = {1'b0, operand1} - {1'b0, operand2};
	assign zero = difference == '0;
	assign overflow = operand1[31] != operand2[31] && difference[31] == operand2[31];
	assign signed_gtr = overflow == difference[31];

	always_comb
	begin
		case (alu_op)
			OP_EQUAL:  compare = zero;
			OP_NEQUAL: compare = !zero;
			OP_SIGTR:  compare = signed_gtr && !zero;
			OP_SIGTE:  compare = signed_gtr || zero;
			OP_SILT:   compare = !signed_gtr && !zero;
			OP_SILTE:  compare = !signed_gtr || zero;
			OP_UIGTR:  compare = !borrow && !zero;
			OP_UIGTE:  compare = !borrow || zero;
			OP_UILT:   compare = borrow && !zero;
			OP_UILTE:  compare = borrow || zero;
			default:   compare = 1'b0;
		endcase
	end

	// Highest set bit wins for leading zeros, lowest for trailing
	always_comb
	begin
		lz = 6'd32;
		tz = 6'd32;
		for (int i = 0; i < 32; i++)
			if (operand2[i])
				lz = 6'(31 - i);
		for (int i = 31; i >= 0; i--)
			if (operand2[i])
				tz = 6'(i);
	end

	assign shift_in_sign = alu_op == OP_ASR ? operand1[31] : 1'b0;
	assign rshift_ext = {{32{shift_in_sign}}, operand1} >> operand2[4:0];
	assign lane_sel = operand2[LANE_SEL_W-1:0];

	always_comb
	begin
		case (alu_op)
			OP_OR:   result = operand1 | operand2;
			OP_AND:  result = operand1 & operand2;
			OP_XOR:  result = operand1 ^ operand2;
			OP_IADD: result = operand1 + operand2;
			OP_ISUB: result = difference;
			OP_LSL:  result = operand1 << operand2[4:0];
			OP_LSR,
			OP_ASR:  result = rshift_ext[31:0];
			OP_CLZ:  result = {26'd0, lz};
			OP_CTZ:  result = {26'd0, tz};
			OP_COPY: result = operand2;
			OP_EQUAL, OP_NEQUAL, OP_SIGTR, OP_SIGTE, OP_SILT, OP_SILTE,
			OP_UIGTR, OP_UIGTE, OP_UILT, OP_UILTE:
				result = {31'd0, compare};
			OP_SEXT8:  result = {{24{operand2[7]}}, operand2[7:0]};
			OP_SEXT16: result = {{16{operand2[15]}}, operand2[15:0]};
			OP_SHUFFLE,
			OP_GETLANE: result = vector_operand1[lane_sel];
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/branch_resolve.sv */
// Branch condition and target for the execute stage, evaluated on the lane 0 operand
`timescale 1ns/1ns
`default_nettype none

module branch_resolve
	import exec_pkg::*;
(
	input  decoded_instruction_t instruction,
	input  scalar_t condition_value,
	output logic taken,
	output scalar_t target_pc
);
	logic all_ones;

	// All-lanes tests look at the low half only
	assign all_ones = condition_value[15:0] == 16'hffff;

	always_comb
	begin
		if (!instruction.is_branch)
			taken = 1'b0;
		else
		begin
			case (instruction.branch_type)
				BRANCH_ALL:      taken = all_ones;
				BRANCH_NOT_ALL:  taken = !all_ones;
				BRANCH_ZERO:     taken = condition_value == '0;
				BRANCH_NOT_ZERO: taken = condition_value != '0;
				BRANCH_ALWAYS,
				BRANCH_CALL_OFFSET,
				BRANCH_CALL_REGISTER: taken = 1'b1;
				default: taken = 1'b0;
			endcase
		end
	end

	// Register calls jump to the operand, everything else is PC relative
	assign target_pc = instruction.branch_type == BRANCH_CALL_REGISTER ? condition_value
		: instruction.pc + 32'd4 + instruction.immediate_value;

endmodule

`default_nettype wire

/* design/single_cycle_execute_stage.sv */
// Single cycle execute stage: lane ALUs and branch resolution, registered toward writeback
`timescale 1ns/1ns
`default_nettype none

`include "exec_cfg.svh"

module single_cycle_execute_stage
	import exec_pkg::*;
(
	input  logic clk,
	input  logic reset,

	// From operand fetch
	input  logic of_instruction_valid,
	input  decoded_instruction_t of_instruction,
	input  vector_t of_operand1,
	input  vector_t of_operand2,
	input  lane_mask_t of_mask_value,
	input  thread_idx_t of_thread_idx,

	// Rollback from writeback
	input  logic wb_rollback_en,
	input  thread_idx_t wb_rollback_thread_idx,

	// To writeback
	output logic sx_instruction_valid,
	output decoded_instruction_t sx_instruction,
	output vector_t sx_result,
	output lane_mask_t sx_mask_value,
	output thread_idx_t sx_thread_idx,
	output logic sx_rollback_en,
	output scalar_t sx_rollback_pc
);
	vector_t lane_result;
	logic branch_taken;
	scalar_t branch_target;
	logic squash;
	logic accept;

	genvar lane;
	generate
		for (lane = 0; lane < `VECTOR_LANES; lane++)
		begin : lane_gen
			lane_alu lane_alu_i (
				.alu_op(of_instruction.alu_op),
				.operand1(of_operand1[lane]),
				.operand2(of_operand2[lane]),
				.vector_operand1(of_operand1),
				.result(lane_result[lane])
			);
		end
	endgenerate

	branch_resolve branch_resolve_i (
		.instruction(of_instruction),
		.condition_value(of_operand1[0]),
		.taken(branch_taken),
		.target_pc(branch_target)
	);

	// Drop younger work of the thread being rolled back
	assign squash = wb_rollback_en && wb_rollback_thread_idx == of_thread_idx;
	assign accept = of_instruction_valid && !squash;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sx_instruction_valid <= 1'b0;
			sx_rollback_en <= 1'b0;
		end
		else
		begin
			sx_instruction_valid <= accept;
			sx_rollback_en <= accept && branch_taken;
		end
	end

	always_ff @(posedge clk)
	begin
		sx_instruction <= of_instruction;
		sx_result <= lane_result;
		sx_mask_value <= of_mask_value;
		sx_thread_idx <= of_thread_idx;
		sx_rollback_pc <= branch_target;
	end

endmodule

`default_nettype wire

/* design/writeback_stage.sv */
// Writeback stage: turns execute results into register writes and taken branches into rollback
`timescale 1ns/1ns
`default_nettype none

module writeback_stage
	import exec_pkg::*;
(
	input  logic clk,
	input  logic reset,

	// From execute
	input  logic sx_instruction_valid,
	input  decoded_instruction_t sx_instruction,
	input  vector_t sx_result,
	input  lane_mask_t sx_mask_value,
	input  thread_idx_t sx_thread_idx,
	input  logic sx_rollback_en,
	input  scalar_t sx_rollback_pc,

	// Register file write
	output logic wb_en,
	output reg_idx_t wb_dest_reg,
	output thread_idx_t wb_thread_idx,
	output vector_t wb_result,
	output lane_mask_t wb_write_mask,

	// Redirect, also the squash source for execute
	output logic wb_rollback_en,
	output thread_idx_t wb_rollback_thread_idx,
	output scalar_t wb_rollback_pc
);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb_en <= 1'b0;
			wb_rollback_en <= 1'b0;
		end
		else
		begin
			// Branches without a link register write nothing
			wb_en <= sx_instruction_valid && sx_instruction.has_dest;
			wb_rollback_en <= sx_rollback_en;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_dest_reg <= sx_instruction.dest_reg;
		wb_thread_idx <= sx_thread_idx;
		wb_result <= sx_result;
		wb_write_mask <= sx_mask_value;
		wb_rollback_thread_idx <= sx_thread_idx;
		wb_rollback_pc <= sx_rollback_pc;
	end

endmodule

`default_nettype wire

/* design/exec_core.sv */
// Top of the execute path: connects the execute stage to the writeback stage
`timescale 1ns/1ns
`default_nettype none

module exec_core
	import exec_pkg::*;
(
	input  logic clk,
	input  logic reset,

	input  logic of_instruction_valid,
	input  decoded_instruction_t of_instruction,
	input  vector_t of_operand1,
	input  vector_t of_operand2,
	input  lane_mask_t of_mask_value,
	input  thread_idx_t of_thread_idx,

	output logic wb_en,
	output reg_idx_t wb_dest_reg,
	output thread_idx_t wb_thread_idx,
	output vector_t wb_result,
	output lane_mask_t wb_write_mask,
	output logic wb_rollback_en,
	output thread_idx_t wb_rollback_thread_idx,
	output scalar_t wb_rollback_pc
);
	logic sx_instruction_valid;
	decoded_instruction_t sx_instruction;
	vector_t sx_result;
	lane_mask_t sx_mask_value;
	thread_idx_t sx_thread_idx;
	logic sx_rollback_en;
	scalar_t sx_rollback_pc;

	single_cycle_execute_stage single_cycle_execute_stage_i (
		.clk(clk),
		.reset(reset),
		.of_instruction_valid(of_instruction_valid),
		.of_instruction(of_instruction),
		.of_operand1(of_operand1),
		.of_operand2(of_operand2),
		.of_mask_value(of_mask_value),
		.of_thread_idx(of_thread_idx),
		.wb_rollback_en(wb_rollback_en),
		.wb_rollback_thread_idx(wb_rollback_thread_idx),
		.sx_instruction_valid(sx_instruction_valid),
		.sx_instruction(sx_instruction),
		.sx_result(sx_result),
		.sx_mask_value(sx_mask_value),
		.sx_thread_idx(sx_thread_idx),
		.sx_rollback_en(sx_rollback_en),
		.sx_rollback_pc(sx_rollback_pc)
	);

	writeback_stage writeback_stage_i (
		.clk(clk),
		.reset(reset),
		.sx_instruction_valid(sx_instruction_valid),
		.sx_instruction(sx_instruction),
		.sx_result(sx_result),
		.sx_mask_value(sx_mask_value),
		.sx_thread_idx(sx_thread_idx),
		.sx_rollback_en(sx_rollback_en),
		.sx_rollback_pc(sx_rollback_pc),
		.wb_en(wb_en),
		.wb_dest_reg(wb_dest_reg),
		.wb_thread_idx(wb_thread_idx),
		.wb_result(wb_result),
		.wb_write_mask(wb_write_mask),
		.wb_rollback_en(wb_rollback_en),
		.wb_rollback_thread_idx(wb_rollback_thread_idx),
		.wb_rollback_pc(wb_rollback_pc)
	);

endmodule

`default_nettype wire

/* verification/exec_core_assert.sv */
// Timing checks on the execute path outputs, bound into the top level by the bind below
`timescale 1ns/1ns
`default_nettype none

module exec_core_assert
	import exec_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic of_instruction_valid,
	input decoded_instruction_t of_instruction,
	input logic wb_en,
	input logic wb_rollback_en,
	input thread_idx_t wb_rollback_thread_idx,
	input scalar_t wb_rollback_pc
);
	int assert_errors = 0;

	// A branch redirects for exactly one cycle
	rollback_single_pulse: assert property (@(posedge clk) disable iff (reset)
		wb_rollback_en |=> !wb_rollback_en || wb_rollback_pc != $past(wb_rollback_pc)
			|| wb_rollback_thread_idx != $past(wb_rollback_thread_idx))
	else
	begin
		$error("rollback held for two cycles by one branch");
		assert_errors++;
	end

	reset_outputs_low: assert property (@(posedge clk)
		$fell(reset) |-> !wb_en && !wb_rollback_en)
	else
	begin
		$error("writeback outputs active in the cycle after reset");
		assert_errors++;
	end

	// Rollback comes two edges after the branch entered execute
	rollback_after_branch: assert property (@(posedge clk) disable iff (reset)
		wb_rollback_en |-> $past(of_instruction_valid && of_instruction.is_branch, 2))
	else
	begin
		$error("rollback without a valid branch two cycles earlier");
		assert_errors++;
	end

endmodule

bind exec_core exec_core_assert exec_core_assert_i (
	.clk(clk),
	.reset(reset),
	.of_instruction_valid(of_instruction_valid),
	.of_instruction(of_instruction),
	.wb_en(wb_en),
	.wb_rollback_en(wb_rollback_en),
	.wb_rollback_thread_idx(wb_rollback_thread_idx),
	.wb_rollback_pc(wb_rollback_pc)
);

`default_nettype wire

/* verification/exec_core_tb.sv */
// Directed testbench for the execute path top level; compile with the project file list
`timescale 1ns/1ns
`default_nettype none

`include "exec_cfg.svh"

module exec_core_tb
	import exec_pkg::*;
();
	localparam int RESET_CYCLES = 8;
	localparam int TEST_OPS = 160;
	localparam int OP_CYCLES = 3;
	localparam int SQUASH_CYCLES = 12;
	// Four times the expected run length
	localparam int TIMEOUT_CYCLES = 4 * (RESET_CYCLES + TEST_OPS * OP_CYCLES + SQUASH_CYCLES);

	logic clk = 1'b0;
	logic reset;
	logic of_instruction_valid;
	decoded_instruction_t of_instruction;
	vector_t of_operand1;
	vector_t of_operand2;
	lane_mask_t of_mask_value;
	thread_idx_t of_thread_idx;
	logic wb_en;
	reg_idx_t wb_dest_reg;
	thread_idx_t wb_thread_idx;
	vector_t wb_result;
	lane_mask_t wb_write_mask;
	logic wb_rollback_en;
	thread_idx_t wb_rollback_thread_idx;
	scalar_t wb_rollback_pc;
	logic [31:0] lfsr_state = 32'h4dc7e2a2;
	int cycle_count = 0;

	exec_core exec_core_i (
		.clk(clk),
		.reset(reset),
		.of_instruction_valid(of_instruction_valid),
		.of_instruction(of_instruction),
		.of_operand1(of_operand1),
		.of_operand2(of_operand2),
		.of_mask_value(of_mask_value),
		.of_thread_idx(of_thread_idx),
		.wb_en(wb_en),
		.wb_dest_reg(wb_dest_reg),
		.wb_thread_idx(wb_thread_idx),
		.wb_result(wb_result),
		.wb_write_mask(wb_write_mask),
		.wb_rollback_en(wb_rollback_en),
		.wb_rollback_thread_idx(wb_rollback_thread_idx),
		.wb_rollback_pc(wb_rollback_pc)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("Result: FAILED");
			$fatal(1, "Timeout");
		end
	end

	// Taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [31:0] random_bits(int count);
		logic [31:0] value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic vector_t random_vector();
		vector_t v;
		for (int lane = 0; lane < `VECTOR_LANES; lane++)
			v[lane] = random_bits(32);
		return v;
	endfunction

	function automatic decoded_instruction_t make_instr(alu_op_t op, logic is_branch,
		branch_type_t branch_type, scalar_t pc, scalar_t imm, logic has_dest, reg_idx_t dest);
		decoded_instruction_t instr;
		instr.pc = pc;
		instr.alu_op = op;
		instr.is_branch = is_branch;
		instr.branch_type = branch_type;
		instr.immediate_value = imm;
		instr.has_dest = has_dest;
		instr.dest_reg = dest;
		return instr;
	endfunction

	function automatic decoded_instruction_t alu_instr(alu_op_t op);
		return make_instr(op, 1'b0, BRANCH_ALL, random_bits(32) & 32'hffff_fffc,
			random_bits(32), 1'b1, reg_idx_t'(random_bits(5)));
	endfunction

	// Expected lane value, straight from the operation definitions
	function automatic scalar_t model_lane(alu_op_t op, scalar_t a, scalar_t b, vector_t va);
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		int zeros = 0;
		sa = a;
		sb = b;
		case (op)
			OP_OR:     return a | b;
			OP_AND:    return a & b;
			OP_XOR:    return a ^ b;
			OP_IADD:   return a + b;
			OP_ISUB:   return a - b;
			OP_LSL:    return a << b[4:0];
			OP_LSR:    return a >> b[4:0];
			OP_ASR:    return sa >>> b[4:0];
			OP_CLZ:
			begin
				while (zeros < 32 && !b[31 - zeros])
					zeros++;
				return scalar_t'(zeros);
			end
			OP_CTZ:
			begin
				while (zeros < 32 && !b[zeros])
					zeros++;
				return scalar_t'(zeros);
			end
			OP_COPY:   return b;
			OP_EQUAL:  return scalar_t'(a == b);
			OP_NEQUAL: return scalar_t'(a != b);
			OP_SIGTR:  return scalar_t'(sa > sb);
			OP_SIGTE:  return scalar_t'(sa >= sb);
			OP_SILT:   return scalar_t'(sa < sb);
			OP_SILTE:  return scalar_t'(sa <= sb);
			OP_UIGTR:  return scalar_t'(a > b);
			OP_UIGTE:  return scalar_t'(a >= b);
			OP_UILT:   return scalar_t'(a < b);
			OP_UILTE:  return scalar_t'(a <= b);
			OP_SEXT8:  return {{24{b[7]}}, b[7:0]};
			OP_SEXT16: return {{16{b[15]}}, b[15:0]};
			OP_SHUFFLE,
			OP_GETLANE: return va[b % `VECTOR_LANES];
			default:   return '0;
		endcase
	endfunction

	function automatic logic expect_taken(decoded_instruction_t instr, scalar_t cond);
		if (!instr.is_branch)
			return 1'b0;
		case (instr.branch_type)
			BRANCH_ALL:      return &cond[15:0];
			BRANCH_NOT_ALL:  return !(&cond[15:0]);
			BRANCH_ZERO:     return cond == '0;
			BRANCH_NOT_ZERO: return cond != '0;
			BRANCH_ALWAYS,
			BRANCH_CALL_OFFSET,
			BRANCH_CALL_REGISTER: return 1'b1;
			default:         return 1'b0;
		endcase
	endfunction

	function automatic scalar_t expect_target(decoded_instruction_t instr, scalar_t cond);
		if (instr.branch_type == BRANCH_CALL_REGISTER)
			return cond;
		return instr.pc + 32'd4 + instr.immediate_value;
	endfunction

	task automatic check(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual)
		begin
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	task automatic drive(input decoded_instruction_t instr, input vector_t op1,
		input vector_t op2, input lane_mask_t mask, input thread_idx_t thread);
		of_instruction_valid <= 1'b1;
		of_instruction <= instr;
		of_operand1 <= op1;
		of_operand2 <= op2;
		of_mask_value <= mask;
		of_thread_idx <= thread;
	endtask

	// Issue one instruction alone and check the writeback two edges later
	task automatic run_op(input string name, input decoded_instruction_t instr,
		input vector_t op1, input vector_t op2, input lane_mask_t mask,
		input thread_idx_t thread);
		vector_t expected;
		logic taken;
		for (int lane = 0; lane < `VECTOR_LANES; lane++)
			expected[lane] = model_lane(instr.alu_op, op1[lane], op2[lane], op1);
		taken = expect_taken(instr, op1[0]);
		@(posedge clk);
		drive(instr, op1, op2, mask, thread);
		@(posedge clk);
		of_instruction_valid <= 1'b0;
		@(negedge clk);
		check({name, " early wb_en"}, 1'b0, wb_en);
		check({name, " early rollback"}, 1'b0, wb_rollback_en);
		@(posedge clk);
		@(negedge clk);
		check({name, " wb_en"}, instr.has_dest, wb_en);
		if (instr.has_dest)
		begin
			check({name, " dest"}, instr.dest_reg, wb_dest_reg);
			check({name, " thread"}, thread, wb_thread_idx);
			check({name, " mask"}, mask, wb_write_mask);
			check({name, " result"}, expected, wb_result);
		end
		check({name, " rollback"}, taken, wb_rollback_en);
		if (taken)
		begin
			check({name, " rollback thread"}, thread, wb_rollback_thread_idx);
			check({name, " rollback pc"}, expect_target(instr, op1[0]), wb_rollback_pc);
		end
	endtask

	task automatic test_arith();
		alu_op_t ops[10] = '{OP_OR, OP_AND, OP_XOR, OP_IADD, OP_ISUB,
			OP_LSL, OP_LSR, OP_ASR, OP_SEXT8, OP_SEXT16};
		for (int rep = 0; rep < 8; rep++)
			foreach (ops[i])
				run_op($sformatf("arith %s", ops[i].name()), alu_instr(ops[i]),
					random_vector(), random_vector(),
					lane_mask_t'(random_bits(`VECTOR_LANES)), thread_idx_t'(random_bits(2)));
	endtask

	task automatic test_compare();
		alu_op_t ops[10] = '{OP_EQUAL, OP_NEQUAL, OP_SIGTR, OP_SIGTE, OP_SILT,
			OP_SILTE, OP_UIGTR, OP_UIGTE, OP_UILT, OP_UILTE};
		alu_op_t counts[2] = '{OP_CLZ, OP_CTZ};
		vector_t a;
		vector_t b;
		foreach (ops[i])
		begin
			a = random_vector();
			b = random_vector();
			run_op($sformatf("%s random", ops[i].name()), alu_instr(ops[i]), a, b, '1, 2'd0);
			run_op($sformatf("%s equal", ops[i].name()), alu_instr(ops[i]), a, a, '1, 2'd1);
			// Opposite signs, alternating which side is negative
			for (int lane = 0; lane < `VECTOR_LANES; lane++)
			begin
				a[lane][31] = (lane % 2) == 1;
				b[lane][31] = (lane % 2) == 0;
			end
			run_op($sformatf("%s sign", ops[i].name()), alu_instr(ops[i]), a, b, '1, 2'd2);
		end
		foreach (counts[i])
		begin
			run_op($sformatf("%s zero", counts[i].name()), alu_instr(counts[i]),
				random_vector(), '0, '1, 2'd3);
			repeat (4)
			begin
				for (int lane = 0; lane < `VECTOR_LANES; lane++)
					b[lane] = 32'd1 << random_bits(5);
				run_op($sformatf("%s one bit", counts[i].name()), alu_instr(counts[i]),
					random_vector(), b, '1, 2'd0);
			end
			repeat (2)
				run_op($sformatf("%s random", counts[i].name()), alu_instr(counts[i]),
					random_vector(), random_vector(), '1, 2'd1);
		end
	endtask

	task automatic test_shuffle();
		alu_op_t ops[2] = '{OP_SHUFFLE, OP_GETLANE};
		foreach (ops[i])
			repeat (4)
				run_op($sformatf("lane select %s", ops[i].name()), alu_instr(ops[i]),
					random_vector(), random_vector(), lane_mask_t'(random_bits(`VECTOR_LANES)),
					thread_idx_t'(random_bits(2)));
	endtask

	task automatic test_branch();
		branch_type_t types[7] = '{BRANCH_ALL, BRANCH_ZERO, BRANCH_NOT_ZERO, BRANCH_ALWAYS,
			BRANCH_CALL_OFFSET, BRANCH_NOT_ALL, BRANCH_CALL_REGISTER};
		scalar_t conds[3];
		decoded_instruction_t instr;
		vector_t a;
		foreach (types[i])
		begin
			instr = make_instr(OP_COPY, 1'b1, types[i], random_bits(32) & 32'hffff_fffc,
				random_bits(32), 1'b0, '0);
			// Low half all ones, zero, and a nonzero value that is not all ones
			conds[0] = random_bits(32) | 32'h0000_ffff;
			conds[1] = '0;
			conds[2] = (random_bits(32) & 32'hffff_fffe) | 32'h2;
			foreach (conds[k])
			begin
				a = random_vector();
				a[0] = conds[k];
				run_op($sformatf("branch %s cond %0d", types[i].name(), k), instr,
					a, random_vector(), '1, thread_idx_t'(random_bits(2)));
			end
			instr.is_branch = 1'b0;
			run_op($sformatf("branch %s disabled", types[i].name()), instr,
				random_vector(), random_vector(), '1, thread_idx_t'(random_bits(2)));
		end
	endtask

	// Branch on thread 1, one filler, then an instruction of late_thread in the squash slot
	task automatic squash_run(input thread_idx_t late_thread);
		decoded_instruction_t branch;
		decoded_instruction_t filler;
		decoded_instruction_t late;
		vector_t a;
		vector_t b;
		branch = make_instr(OP_COPY, 1'b1, BRANCH_ALWAYS, 32'h100, 32'h40, 1'b0, '0);
		filler = make_instr(OP_XOR, 1'b0, BRANCH_ALL, 32'h104, '0, 1'b1, 5'd3);
		late = make_instr(OP_IADD, 1'b0, BRANCH_ALL, 32'h108, '0, 1'b1, 5'd7);
		a = random_vector();
		b = random_vector();
		@(posedge clk);
		drive(branch, a, b, '1, 2'd1);
		@(posedge clk);
		drive(filler, a, b, '1, 2'd0);
		@(posedge clk);
		drive(late, a, b, '1, late_thread);
		@(negedge clk);
		check("squash rollback", 1'b1, wb_rollback_en);
		check("squash rollback thread", 2'd1, wb_rollback_thread_idx);
		check("squash rollback pc", expect_target(branch, a[0]), wb_rollback_pc);
		check("squash branch wb_en", 1'b0, wb_en);
		@(posedge clk);
		of_instruction_valid <= 1'b0;
		@(negedge clk);
		check("squash filler wb_en", 1'b1, wb_en);
		check("squash filler thread", 2'd0, wb_thread_idx);
		check("squash rollback pulse", 1'b0, wb_rollback_en);
		@(posedge clk);
		@(negedge clk);
		check("squash late wb_en", late_thread != 2'd1, wb_en);
		if (late_thread != 2'd1)
		begin
			check("squash late thread", late_thread, wb_thread_idx);
			check("squash late result", scalar_t'(a[0] + b[0]), wb_result[0]);
		end
	endtask

	initial
	begin
		reset = 1'b1;
		of_instruction_valid = 1'b0;
		of_instruction = '0;
		of_operand1 = '0;
		of_operand2 = '0;
		of_mask_value = '0;
		of_thread_idx = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		test_arith();
		test_compare();
		test_shuffle();
		test_branch();
		squash_run(2'd1);
		squash_run(2'd2);
		repeat (2) @(posedge clk);
		if (exec_core_i.exec_core_assert_i.assert_errors == 0)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
		begin
			$display("%0d assertion failures", exec_core_i.exec_core_assert_i.assert_errors);
			$display("Result: FAILED");
			$fatal(1, "Assertion failures");
		end
	end

endmodule

`default_nettype wire

/* exec_core.f */
+incdir+design
design/exec_pkg.sv
design/lane_alu.sv
design/branch_resolve.sv
design/single_cycle_execute_stage.sv
design/writeback_stage.sv
design/exec_core.sv
verification/exec_core_assert.sv
verification/exec_core_tb.sv
